//--- common/harness_cfg_pkg.sv
// machine sizes and timing constants, imported by the harness RTL and its testbench
`default_nettype none

package harness_cfg_pkg;

  // link organisation of the vcache banks
  localparam int NUM_RUCHE = 2;
  localparam int SLOTS_PER_LINK = 4;
  localparam int NUM_VCACHES = NUM_RUCHE * SLOTS_PER_LINK;

  // vcache to test dram channel grouping
  localparam int VCACHES_PER_CHANNEL = 4;
  localparam int NUM_CHANNELS = NUM_VCACHES / VCACHES_PER_CHANNEL;

  // dma block geometry
  localparam int BLOCK_WORDS = 4;
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 12;

  // one word per 4 bytes of the byte address space
  localparam int MEM_WORDS = (1 << ADDR_WIDTH) / (DATA_WIDTH / 8);

  // derived address fields
  localparam int BYTE_OFFSET_WIDTH = $clog2(DATA_WIDTH / 8);
  localparam int MEM_ADDR_WIDTH = ADDR_WIDTH - BYTE_OFFSET_WIDTH;
  localparam int BLOCK_OFFSET_WIDTH = $clog2(BLOCK_WORDS);
  localparam int BLOCK_ADDR_WIDTH = MEM_ADDR_WIDTH - BLOCK_OFFSET_WIDTH;

  // reset and tag programming timing
  localparam int TAG_PROGRAM_CYCLES = 8;
  localparam int TAG_CNT_WIDTH = $clog2(TAG_PROGRAM_CYCLES + 1);
  localparam int RESET_DEPTH = 3;

endpackage

`default_nettype wire

//--- common/cache_dma_pkg.sv
// vcache DMA packet, data word and channel index types shared by the harness blocks
`default_nettype none

package cache_dma_pkg;

  // block request from a vcache, address is block aligned
  typedef struct packed {
    logic                                  write_not_read;
    logic [harness_cfg_pkg::ADDR_WIDTH-1:0] addr;
  } dma_pkt_t;

  // one word on the dma data lines
  typedef logic [harness_cfg_pkg::DATA_WIDTH-1:0] dma_word_t;

  // position of a vcache inside its channel
  typedef logic [$clog2(harness_cfg_pkg::VCACHES_PER_CHANNEL)-1:0] vcache_idx_t;

endpackage

`default_nettype wire

//--- source/reset_sequencer.sv
// models tag programming after power-on reset, then releases the core reset through a delay chain
`timescale 1ns/100ps
`default_nettype none

module reset_sequencer (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic tag_done_o,
  output logic core_reset_o
);

  import harness_cfg_pkg::*;

  logic [TAG_CNT_WIDTH-1:0] tag_cnt_r;
  logic [RESET_DEPTH-1:0]   reset_chain_r;

  // tag programming counter, stops once done
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tag_cnt_r  <= '0;
      tag_done_o <= 1'b0;
    end else if (!tag_done_o) begin
      tag_cnt_r <= tag_cnt_r + 1'b1;
      if (tag_cnt_r == TAG_CNT_WIDTH'(TAG_PROGRAM_CYCLES - 1)) begin
        tag_done_o <= 1'b1;
      end
    end
  end

  // core stays in reset until the chain drains
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      reset_chain_r <= '1;
    end else begin
      reset_chain_r <= {reset_chain_r[RESET_DEPTH-2:0], ~tag_done_o};
    end
  end

  assign core_reset_o = reset_chain_r[RESET_DEPTH-1];

endmodule

`default_nettype wire

//--- test_dram/dma_channel_arbiter.sv
// round-robin pick of one requesting vcache for an idle test dram channel
`timescale 1ns/100ps
`default_nettype none

module dma_channel_arbiter (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  input  logic                                            core_reset_i,
  input  logic [harness_cfg_pkg::VCACHES_PER_CHANNEL-1:0] req_v_i,
  input  logic                                            idle_i,
  output logic                                            grant_v_o,
  output cache_dma_pkg::vcache_idx_t                      grant_idx_o
);

  import harness_cfg_pkg::*;
  import cache_dma_pkg::*;

  vcache_idx_t last_grant_r;
  vcache_idx_t cand_idx;
  vcache_idx_t pick_idx;
  logic        pick_found;

  // search forward from the slot after the last grant
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = last_grant_r;
    cand_idx   = last_grant_r;
    for (int i = 1; i <= VCACHES_PER_CHANNEL; i++) begin
      cand_idx = last_grant_r + vcache_idx_t'(i);
      if (!pick_found && req_v_i[cand_idx]) begin
        pick_found = 1'b1;
        pick_idx   = cand_idx;
      end
    end
  end

  assign grant_v_o   = idle_i & pick_found & ~core_reset_i;
  assign grant_idx_o = pick_idx;

  // start at the top so position 0 wins first
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_grant_r <= vcache_idx_t'(VCACHES_PER_CHANNEL - 1);
    end else if (core_reset_i) begin
      last_grant_r <= vcache_idx_t'(VCACHES_PER_CHANNEL - 1);
    end else if (grant_v_o) begin
      last_grant_r <= grant_idx_o;
    end
  end

endmodule

`default_nettype wire

//--- test_dram/test_dram_channel.sv
// test dram channel: serves DMA block reads and writes of its vcaches from a local memory
`timescale 1ns/100ps
`default_nettype none

module test_dram_channel (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic core_reset_i,

  input  cache_dma_pkg::dma_pkt_t  [harness_cfg_pkg::VCACHES_PER_CHANNEL-1:0] pkt_i,
  input  logic                     [harness_cfg_pkg::VCACHES_PER_CHANNEL-1:0] pkt_v_i,
  output logic                     [harness_cfg_pkg::VCACHES_PER_CHANNEL-1:0] pkt_yumi_o,

  input  cache_dma_pkg::dma_word_t [harness_cfg_pkg::VCACHES_PER_CHANNEL-1:0] data_i,
  input  logic                     [harness_cfg_pkg::VCACHES_PER_CHANNEL-1:0] data_v_i,
  output logic                     [harness_cfg_pkg::VCACHES_PER_CHANNEL-1:0] data_ready_o,

  output cache_dma_pkg::dma_word_t [harness_cfg_pkg::VCACHES_PER_CHANNEL-1:0] data_o,
  output logic                     [harness_cfg_pkg::VCACHES_PER_CHANNEL-1:0] data_v_o,
  input  logic                     [harness_cfg_pkg::VCACHES_PER_CHANNEL-1:0] data_yumi_i
);

  import harness_cfg_pkg::*;
  import cache_dma_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ
  } state_e;

  state_e                        state_r;
  logic                          accept_r;
  vcache_idx_t                   idx_r;
  dma_pkt_t                      pkt_r;
  logic [BLOCK_OFFSET_WIDTH-1:0] word_cnt_r;
  logic                          rd_v_r;
  dma_word_t                     rd_data_r;
  dma_word_t                     mem [MEM_WORDS];

  logic                          idle;
  logic                          grant_v;
  vcache_idx_t                   grant_idx;
  logic [BLOCK_ADDR_WIDTH-1:0]   blk_addr;
  logic [BLOCK_OFFSET_WIDTH-1:0] rd_cnt;
  logic [MEM_ADDR_WIDTH-1:0]     wr_addr;
  logic [MEM_ADDR_WIDTH-1:0]     rd_addr;
  logic                          wr_fire;
  logic                          rd_fire;
  logic                          rd_load;
  logic                          last_word;

  assign idle = (state_r == ST_IDLE);

  dma_channel_arbiter arb (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .core_reset_i (core_reset_i),
    .req_v_i      (pkt_v_i),
    .idle_i       (idle),
    .grant_v_o    (grant_v),
    .grant_idx_o  (grant_idx)
  );

  // block offset bits of the packet address are dropped
  assign blk_addr  = pkt_r.addr[ADDR_WIDTH-1 -: BLOCK_ADDR_WIDTH];
  assign last_word = (word_cnt_r == BLOCK_OFFSET_WIDTH'(BLOCK_WORDS - 1));
  assign wr_fire   = (state_r == ST_WRITE) & ~accept_r & data_v_i[idx_r];
  assign rd_fire   = rd_v_r & data_yumi_i[idx_r];
  assign rd_load   = (state_r == ST_READ) & (accept_r | (rd_fire & ~last_word));
  assign rd_cnt    = accept_r ? '0 : word_cnt_r + 1'b1;
  assign wr_addr   = {blk_addr, word_cnt_r};
  assign rd_addr   = {blk_addr, rd_cnt};

  // only the served vcache sees strobes
  always_comb begin
    pkt_yumi_o   = '0;
    data_ready_o = '0;
    data_v_o     = '0;
    pkt_yumi_o[idx_r]   = accept_r;
    data_ready_o[idx_r] = (state_r == ST_WRITE) & ~accept_r;
    data_v_o[idx_r]     = rd_v_r;
    for (int i = 0; i < VCACHES_PER_CHANNEL; i++) begin
      data_o[i] = rd_data_r;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r    <= ST_IDLE;
      accept_r   <= 1'b0;
      idx_r      <= '0;
      word_cnt_r <= '0;
      rd_v_r     <= 1'b0;
    end else if (core_reset_i) begin
      state_r    <= ST_IDLE;
      accept_r   <= 1'b0;
      idx_r      <= '0;
      word_cnt_r <= '0;
      rd_v_r     <= 1'b0;
    end else begin
      accept_r <= 1'b0;
      case (state_r)
        ST_IDLE: begin
          if (grant_v) begin
            idx_r      <= grant_idx;
            accept_r   <= 1'b1;
            word_cnt_r <= '0;
            state_r    <= pkt_i[grant_idx].write_not_read ? ST_WRITE : ST_READ;
          end
        end
        ST_WRITE: begin
          if (wr_fire) begin
            word_cnt_r <= word_cnt_r + 1'b1;
            if (last_word) begin
              state_r <= ST_IDLE;
            end
          end
        end
        ST_READ: begin
          // first word goes out the cycle after the yumi
          if (accept_r) begin
            rd_v_r <= 1'b1;
          end else if (rd_fire) begin
            if (last_word) begin
              rd_v_r  <= 1'b0;
              state_r <= ST_IDLE;
            end else begin
              word_cnt_r <= word_cnt_r + 1'b1;
            end
          end
        end
        default: state_r <= ST_IDLE;
      endcase
    end
  end

  // memory, latched request and outgoing read word
  always_ff @(posedge clk_i) begin
    if (idle && grant_v) begin
      pkt_r <= pkt_i[grant_idx];
    end
    if (wr_fire) begin
      mem[wr_addr] <= data_i[idx_r];
    end
    if (rd_load) begin
      rd_data_r <= mem[rd_addr];
    end
  end

  // dram contents start at zero
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

endmodule

`default_nettype wire

//--- source/manycore_mem_harness.sv
// memory-side harness top: maps ruched vcache DMA ports onto test dram channels
`timescale 1ns/100ps
`default_nettype none

module manycore_mem_harness (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic tag_done_o,

  input  cache_dma_pkg::dma_pkt_t
         [harness_cfg_pkg::NUM_RUCHE-1:0][harness_cfg_pkg::SLOTS_PER_LINK-1:0] dma_pkt_i,
  input  logic
         [harness_cfg_pkg::NUM_RUCHE-1:0][harness_cfg_pkg::SLOTS_PER_LINK-1:0] dma_pkt_v_i,
  output logic
         [harness_cfg_pkg::NUM_RUCHE-1:0][harness_cfg_pkg::SLOTS_PER_LINK-1:0] dma_pkt_yumi_o,

  input  cache_dma_pkg::dma_word_t
         [harness_cfg_pkg::NUM_RUCHE-1:0][harness_cfg_pkg::SLOTS_PER_LINK-1:0] dma_data_i,
  input  logic
         [harness_cfg_pkg::NUM_RUCHE-1:0][harness_cfg_pkg::SLOTS_PER_LINK-1:0] dma_data_v_i,
  output logic
         [harness_cfg_pkg::NUM_RUCHE-1:0][harness_cfg_pkg::SLOTS_PER_LINK-1:0] dma_data_ready_o,

  output cache_dma_pkg::dma_word_t
         [harness_cfg_pkg::NUM_RUCHE-1:0][harness_cfg_pkg::SLOTS_PER_LINK-1:0] dma_data_o,
  output logic
         [harness_cfg_pkg::NUM_RUCHE-1:0][harness_cfg_pkg::SLOTS_PER_LINK-1:0] dma_data_v_o,
  input  logic
         [harness_cfg_pkg::NUM_RUCHE-1:0][harness_cfg_pkg::SLOTS_PER_LINK-1:0] dma_data_yumi_i
);

  import harness_cfg_pkg::*;
  import cache_dma_pkg::*;

  logic core_reset;

  // flat vcache view, index = slot * NUM_RUCHE + ruche
  dma_pkt_t  [NUM_VCACHES-1:0] flat_pkt;
  logic      [NUM_VCACHES-1:0] flat_pkt_v;
  logic      [NUM_VCACHES-1:0] flat_pkt_yumi;
  dma_word_t [NUM_VCACHES-1:0] flat_wr_data;
  logic      [NUM_VCACHES-1:0] flat_wr_data_v;
  logic      [NUM_VCACHES-1:0] flat_wr_data_ready;
  dma_word_t [NUM_VCACHES-1:0] flat_rd_data;
  logic      [NUM_VCACHES-1:0] flat_rd_data_v;
  logic      [NUM_VCACHES-1:0] flat_rd_data_yumi;

  reset_sequencer rst_seq (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .tag_done_o   (tag_done_o),
    .core_reset_o (core_reset)
  );

  // unruched mapping
  for (genvar l = 0; l < NUM_VCACHES; l++) begin : unruche
    localparam int ruche_idx = l % NUM_RUCHE;
    localparam int slot_idx = l / NUM_RUCHE;

    assign flat_pkt[l]       = dma_pkt_i[ruche_idx][slot_idx];
    assign flat_pkt_v[l]     = dma_pkt_v_i[ruche_idx][slot_idx];
    assign flat_wr_data[l]   = dma_data_i[ruche_idx][slot_idx];
    assign flat_wr_data_v[l] = dma_data_v_i[ruche_idx][slot_idx];
    assign flat_rd_data_yumi[l] = dma_data_yumi_i[ruche_idx][slot_idx];

    assign dma_pkt_yumi_o[ruche_idx][slot_idx]   = flat_pkt_yumi[l];
    assign dma_data_ready_o[ruche_idx][slot_idx] = flat_wr_data_ready[l];
    assign dma_data_o[ruche_idx][slot_idx]       = flat_rd_data[l];
    assign dma_data_v_o[ruche_idx][slot_idx]     = flat_rd_data_v[l];
  end

  // consecutive flat indices share a channel
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : chan
    test_dram_channel dram (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .core_reset_i (core_reset),
      .pkt_i        (flat_pkt[c*VCACHES_PER_CHANNEL +: VCACHES_PER_CHANNEL]),
      .pkt_v_i      (flat_pkt_v[c*VCACHES_PER_CHANNEL +: VCACHES_PER_CHANNEL]),
      .pkt_yumi_o   (flat_pkt_yumi[c*VCACHES_PER_CHANNEL +: VCACHES_PER_CHANNEL]),
      .data_i       (flat_wr_data[c*VCACHES_PER_CHANNEL +: VCACHES_PER_CHANNEL]),
      .data_v_i     (flat_wr_data_v[c*VCACHES_PER_CHANNEL +: VCACHES_PER_CHANNEL]),
      .data_ready_o (flat_wr_data_ready[c*VCACHES_PER_CHANNEL +: VCACHES_PER_CHANNEL]),
      .data_o       (flat_rd_data[c*VCACHES_PER_CHANNEL +: VCACHES_PER_CHANNEL]),
      .data_v_o     (flat_rd_data_v[c*VCACHES_PER_CHANNEL +: VCACHES_PER_CHANNEL]),
      .data_yumi_i  (flat_rd_data_yumi[c*VCACHES_PER_CHANNEL +: VCACHES_PER_CHANNEL])
    );
  end

endmodule

`default_nettype wire

//--- test/harness_assertions.sv
// concurrent handshake and reset checks bound into every test dram channel of the harness
`timescale 1ns/100ps
`default_nettype none

module harness_assertions (
  input logic                                            clk_i,
  input logic                                            rst_n_i,
  input logic                                            core_reset_i,
  input logic [harness_cfg_pkg::VCACHES_PER_CHANNEL-1:0] pkt_v_i,
  input logic [harness_cfg_pkg::VCACHES_PER_CHANNEL-1:0] pkt_yumi_o,
  input logic [harness_cfg_pkg::VCACHES_PER_CHANNEL-1:0] data_ready_o,
  input logic [harness_cfg_pkg::VCACHES_PER_CHANNEL-1:0] data_v_o
);

  int fail_cnt = 0;

  // a packet is only taken while its valid is up
  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (pkt_yumi_o & ~pkt_v_i) == '0)
    else begin
      $error("packet yumi without packet valid");
      fail_cnt++;
    end

  // no new grant while a block is still moving
  single_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|pkt_yumi_o) |-> (data_ready_o == '0 && data_v_o == '0))
    else begin
      $error("packet yumi while a block transfer is still running");
      fail_cnt++;
    end

  quiet_in_core_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_reset_i |-> (pkt_yumi_o == '0 && data_ready_o == '0 && data_v_o == '0))
    else begin
      $error("handshake strobe while core reset is high");
      fail_cnt++;
    end

endmodule

bind test_dram_channel harness_assertions chk (.*);

`default_nettype wire

//--- test/tb_manycore_mem_harness.sv
// testbench for the memory harness: reset sequence, block reads and writes, arbitration order
`timescale 1ns/100ps
`default_nettype none

module tb_manycore_mem_harness;

  import harness_cfg_pkg::*;
  import cache_dma_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam int RANDOM_OPS = 40;
  // reset read, two arbitration rounds, directed blocks, random blocks
  localparam int BLOCK_OPS = 1 + 2 * VCACHES_PER_CHANNEL + 7 + RANDOM_OPS;
  localparam int TIMEOUT_CYCLES =
    RESET_CYCLES + TAG_PROGRAM_CYCLES + RESET_DEPTH + 200 * BLOCK_OPS;

  logic clk_i;
  logic rst_n_i;
  logic tag_done_o;
  dma_pkt_t  [NUM_RUCHE-1:0][SLOTS_PER_LINK-1:0] dma_pkt_i;
  logic      [NUM_RUCHE-1:0][SLOTS_PER_LINK-1:0] dma_pkt_v_i;
  logic      [NUM_RUCHE-1:0][SLOTS_PER_LINK-1:0] dma_pkt_yumi_o;
  dma_word_t [NUM_RUCHE-1:0][SLOTS_PER_LINK-1:0] dma_data_i;
  logic      [NUM_RUCHE-1:0][SLOTS_PER_LINK-1:0] dma_data_v_i;
  logic      [NUM_RUCHE-1:0][SLOTS_PER_LINK-1:0] dma_data_ready_o;
  dma_word_t [NUM_RUCHE-1:0][SLOTS_PER_LINK-1:0] dma_data_o;
  logic      [NUM_RUCHE-1:0][SLOTS_PER_LINK-1:0] dma_data_v_o;
  logic      [NUM_RUCHE-1:0][SLOTS_PER_LINK-1:0] dma_data_yumi_i;

  logic [31:0] rand_state;
  int          checks;
  int          errors;
  dma_word_t   ref_mem [NUM_CHANNELS][MEM_WORDS];
  dma_word_t   exp_q [NUM_VCACHES][$];
  logic        hold_pending [NUM_VCACHES];
  dma_word_t   held_word [NUM_VCACHES];

  manycore_mem_harness uut (.*);

  function automatic logic [31:0] next_rand();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  // unruched order: slot major, ruche minor
  function automatic int flat_index(int r, int s);
    return s * NUM_RUCHE + r;
  endfunction

  function automatic int channel_of(int r, int s);
    return flat_index(r, s) / VCACHES_PER_CHANNEL;
  endfunction

  function automatic int position_of(int r, int s);
    return flat_index(r, s) % VCACHES_PER_CHANNEL;
  endfunction

  function automatic dma_word_t expected_word(int r, int s, logic [ADDR_WIDTH-1:0] addr, int k);
    int base;
    base = (int'(addr) / ((DATA_WIDTH / 8) * BLOCK_WORDS)) * BLOCK_WORDS;
    return ref_mem[channel_of(r, s)][base + k];
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s expected 0x%h actual 0x%h", name, expected, actual);
    end
  endtask

  task automatic push_expected(int r, int s, logic [ADDR_WIDTH-1:0] addr);
    for (int k = 0; k < BLOCK_WORDS; k++) begin
      exp_q[flat_index(r, s)].push_back(expected_word(r, s, addr, k));
    end
  endtask

  task automatic await_accept(int r, int s);
    logic seen;
    do begin
      @(negedge clk_i);
      seen = dma_pkt_yumi_o[r][s];
      @(posedge clk_i);
      #1;
    end while (!seen);
  endtask

  task automatic request(int r, int s, logic wr, logic [ADDR_WIDTH-1:0] addr);
    dma_pkt_i[r][s].write_not_read = wr;
    dma_pkt_i[r][s].addr = addr;
    dma_pkt_v_i[r][s] = 1'b1;
    await_accept(r, s);
    dma_pkt_v_i[r][s] = 1'b0;
  endtask

  // random stall drops yumi three cycles out of four
  task automatic drain_read(int r, int s, bit stall);
    int          fired;
    logic [31:0] rnd;
    fired = 0;
    while (fired < BLOCK_WORDS) begin
      rnd = next_rand();
      dma_data_yumi_i[r][s] = stall ? (rnd[1:0] == 2'b00) : 1'b1;
      @(negedge clk_i);
      if (dma_data_v_o[r][s] && dma_data_yumi_i[r][s]) begin
        fired++;
      end
      @(posedge clk_i);
      #1;
    end
    dma_data_yumi_i[r][s] = 1'b0;
  endtask

  task automatic read_block(int r, int s, logic [ADDR_WIDTH-1:0] addr, bit stall);
    push_expected(r, s, addr);
    request(r, s, 1'b0, addr);
    drain_read(r, s, stall);
  endtask

  task automatic write_block(int r, int s, logic [ADDR_WIDTH-1:0] addr, bit gaps);
    int          base;
    logic        fired;
    logic [31:0] rnd;
    base = (int'(addr) / ((DATA_WIDTH / 8) * BLOCK_WORDS)) * BLOCK_WORDS;
    request(r, s, 1'b1, addr);
    for (int k = 0; k < BLOCK_WORDS; k++) begin
      dma_data_i[r][s] = next_rand();
      fired = 1'b0;
      while (!fired) begin
        rnd = next_rand();
        dma_data_v_i[r][s] = gaps ? rnd[0] : 1'b1;
        @(negedge clk_i);
        fired = dma_data_v_i[r][s] & dma_data_ready_o[r][s];
        @(posedge clk_i);
        #1;
      end
      ref_mem[channel_of(r, s)][base + k] = dma_data_i[r][s];
    end
    dma_data_v_i[r][s] = 1'b0;
  endtask

  initial begin
    clk_i = 1'b0;
    forever begin
      #5 clk_i = ~clk_i;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("timeout after %0d cycles, a DMA handshake never completed", TIMEOUT_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // accepted read words against the reference, held words must not move
  always @(negedge clk_i) begin : compare_reads
    int        l;
    dma_word_t exp_word;
    if (rst_n_i) begin
      for (int r = 0; r < NUM_RUCHE; r++) begin
        for (int s = 0; s < SLOTS_PER_LINK; s++) begin
          l = flat_index(r, s);
          if (hold_pending[l]) begin
            check_value($sformatf("dma_data_v_o[%0d][%0d]", r, s), 32'(1),
                        32'(dma_data_v_o[r][s]));
            check_value($sformatf("dma_data_o[%0d][%0d] held", r, s), held_word[l],
                        dma_data_o[r][s]);
          end
          if (dma_data_v_o[r][s] && dma_data_yumi_i[r][s]) begin
            if (exp_q[l].size() == 0) begin
              errors++;
              $display("unexpected read word on vcache port [%0d][%0d]", r, s);
            end else begin
              exp_word = exp_q[l].pop_front();
              check_value($sformatf("dma_data_o[%0d][%0d]", r, s), exp_word, dma_data_o[r][s]);
            end
          end
          hold_pending[l] = dma_data_v_o[r][s] && !dma_data_yumi_i[r][s];
          held_word[l] = dma_data_o[r][s];
        end
      end
    end
  end

  initial begin
    int                    next_pos;
    int                    fires;
    int                    r;
    int                    s;
    int                    assert_errors;
    int                    remaining [NUM_VCACHES];
    logic [31:0]           rnd;
    logic [ADDR_WIDTH-1:0] addr;
    rand_state = 32'd67086;
    checks = 0;
    errors = 0;
    rst_n_i = 1'b0;
    dma_pkt_i = '0;
    dma_pkt_v_i = '0;
    dma_data_i = '0;
    dma_data_v_i = '0;
    dma_data_yumi_i = '0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        ref_mem[c][w] = '0;
      end
    end
    for (int l = 0; l < NUM_VCACHES; l++) begin
      hold_pending[l] = 1'b0;
      held_word[l] = '0;
    end

    repeat (RESET_CYCLES) begin
      @(negedge clk_i);
      check_value("tag_done_o", 32'(0), 32'(tag_done_o));
      check_value("dma_pkt_yumi_o", 32'(0), 32'(dma_pkt_yumi_o));
      check_value("dma_data_ready_o", 32'(0), 32'(dma_data_ready_o));
      check_value("dma_data_v_o", 32'(0), 32'(dma_data_v_o));
    end
    @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // request waits from release, accepted only after the reset chain drains
    push_expected(0, 0, '0);
    dma_pkt_v_i[0][0] = 1'b1;
    for (int e = 1; e <= TAG_PROGRAM_CYCLES + RESET_DEPTH; e++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_value("tag_done_o", 32'(e >= TAG_PROGRAM_CYCLES), 32'(tag_done_o));
      check_value("dma_pkt_yumi_o", 32'(0), 32'(dma_pkt_yumi_o));
    end
    @(posedge clk_i);
    #1;
    await_accept(0, 0);
    dma_pkt_v_i[0][0] = 1'b0;
    drain_read(0, 0, 1'b0);

    // channel 1 untouched so far, its round robin starts at position 0
    next_pos = 0;
    fires = 0;
    for (r = 0; r < NUM_RUCHE; r++) begin
      for (s = 0; s < SLOTS_PER_LINK; s++) begin
        remaining[flat_index(r, s)] = (channel_of(r, s) == 1) ? 2 : 0;
        if (channel_of(r, s) == 1) begin
          dma_pkt_i[r][s].write_not_read = 1'b0;
          dma_pkt_i[r][s].addr = 12'h040;
          dma_pkt_v_i[r][s] = 1'b1;
          dma_data_yumi_i[r][s] = 1'b1;
        end
      end
    end
    while (fires < 2 * VCACHES_PER_CHANNEL * BLOCK_WORDS) begin
      @(negedge clk_i);
      for (r = 0; r < NUM_RUCHE; r++) begin
        for (s = 0; s < SLOTS_PER_LINK; s++) begin
          if (dma_pkt_yumi_o[r][s]) begin
            check_value("accepted position", 32'(next_pos), 32'(position_of(r, s)));
            next_pos = (next_pos + 1) % VCACHES_PER_CHANNEL;
            remaining[flat_index(r, s)]--;
            push_expected(r, s, dma_pkt_i[r][s].addr);
          end
          if (dma_data_v_o[r][s] && dma_data_yumi_i[r][s]) begin
            fires++;
          end
        end
      end
      @(posedge clk_i);
      #1;
      for (r = 0; r < NUM_RUCHE; r++) begin
        for (s = 0; s < SLOTS_PER_LINK; s++) begin
          if (remaining[flat_index(r, s)] == 0) begin
            dma_pkt_v_i[r][s] = 1'b0;
          end
        end
      end
    end
    dma_data_yumi_i = '0;

    write_block(1, 3, 12'h200, 1'b0);
    read_block(1, 3, 12'h200, 1'b0);
    // [1][0] and [0][1] share channel 0, [0][2] sits in channel 1
    write_block(1, 0, 12'h080, 1'b0);
    read_block(0, 1, 12'h080, 1'b0);
    read_block(0, 2, 12'h080, 1'b0);
    write_block(0, 3, 12'h3f0, 1'b1);
    read_block(0, 3, 12'h3f0, 1'b1);

    repeat (RANDOM_OPS) begin
      rnd = next_rand();
      r = int'(rnd[3:0]) % NUM_RUCHE;
      s = int'(rnd[7:4]) % SLOTS_PER_LINK;
      addr = ADDR_WIDTH'(int'(rnd[11:8]) * (DATA_WIDTH / 8) * BLOCK_WORDS);
      if (rnd[20]) begin
        write_block(r, s, addr, rnd[21]);
      end else begin
        read_block(r, s, addr, rnd[22]);
      end
    end

    repeat (4) @(posedge clk_i);
    for (int l = 0; l < NUM_VCACHES; l++) begin
      if (exp_q[l].size() != 0) begin
        errors++;
        $display("read words never arrived on vcache %0d", l);
      end
    end
    assert_errors = uut.chan[0].dram.chk.fail_cnt + uut.chan[1].dram.chk.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, assert_errors);
    if (errors == 0 && assert_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
common/harness_cfg_pkg.sv
common/cache_dma_pkg.sv
source/reset_sequencer.sv
test_dram/dma_channel_arbiter.sv
test_dram/test_dram_channel.sv
source/manycore_mem_harness.sv
test/harness_assertions.sv
test/tb_manycore_mem_harness.sv

//--- run.sh
#!/bin/sh
# builds the harness testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f project.f --top-module tb_manycore_mem_harness

# assertion failures are counted by the testbench instead of stopping the run
out=$(./obj_dir/Vtb_manycore_mem_harness +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -q "TEST PASS"
